// File: sim.f
+incdir+verilog
verilog/expand_pkg.sv
verilog/expand_ctrl.sv
verilog/expand_shift_buf.sv
verilog/vxu_expand.sv
dv/tb_clk_gen.sv
dv/vxu_expand_sva.sv
dv/tb_vxu_expand.sv

// File: dv/tb_vxu_expand.sv
`timescale 1ns/1ns
`include "expand_macros.svh"

module tb_vxu_expand;

  localparam int SEED     = 74704;
  localparam int N_SINGLE = 7;
  localparam int N_BURST  = 4;
  localparam int N_RANDOM = 60;
  localparam int ROUND    = `EXP_WR_DEPTH + 2;
  localparam int TEST_CYCLES = 16 + N_SINGLE * ROUND + 3 * (N_BURST + ROUND)
                             + N_RANDOM * ROUND;
  localparam int MARGIN   = 20;

  logic                clk;
  logic                reset;
  expand_pkg::issue_t  issue;
  expand_pkg::rd_cmd_t rd_cmd;
  expand_pkg::wr_cmd_t wr_cmd;
  expand_pkg::fu_cmd_t fu_cmd;
  string               test_name;
  int                  timeouts;

  tb_clk_gen u_clk_gen
  (
    .clk   (clk),
    .reset (reset)
  );

  vxu_expand UUT
  (
    .clk    (clk),
    .reset  (reset),
    .issue  (issue),
    .rd_cmd (rd_cmd),
    .wr_cmd (wr_cmd),
    .fu_cmd (fu_cmd)
  );

  bind vxu_expand vxu_expand_sva u_sva
  (
    .clk    (clk),
    .reset  (reset),
    .issue  (issue),
    .rd_cmd (rd_cmd),
    .wr_cmd (wr_cmd),
    .fu_cmd (fu_cmd)
  );

  // Random addresses, counts, flags and function codes
  function automatic expand_pkg::issue_t make_issue
  (
    input expand_pkg::op_t       op,
    input expand_pkg::viu_mode_t mode,
    input logic                  fma
  );
    expand_pkg::issue_t i;
    i          = '0;
    i.op       = op;
    i.last     = 1'($urandom);
    i.cnt      = `EXP_CNT_W'($urandom);
    i.vs       = `EXP_REG_W'($urandom);
    i.vt       = `EXP_REG_W'($urandom);
    i.vr       = `EXP_REG_W'($urandom);
    i.vd       = `EXP_REG_W'($urandom);
    i.vs_zero  = 1'($urandom);
    i.vt_zero  = 1'($urandom);
    i.vr_zero  = 1'($urandom);
    i.viu_mode = mode;
    i.viu_fn   = 4'($urandom);
    i.vau0_fn  = 2'($urandom);
    i.vau1_fn  = {fma, 2'($urandom)};
    i.imm      = `EXP_DATA_W'($urandom);
    return i;
  endfunction

  task automatic send_issue(input expand_pkg::issue_t i);
    @(negedge clk);
    issue = i;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(negedge clk);
      issue = '0;
    end
  endtask

  // One operation, then quiet until its write has left the buffer
  task automatic run_variant(input string phase, input int v);
    expand_pkg::issue_t i;
    string              name;
    case (v)
      0:
      begin
        name = "viu_rr";
        i    = make_issue(expand_pkg::OP_VIU, expand_pkg::VIU_RR, 1'b0);
      end
      1:
      begin
        name = "viu_ri";
        i    = make_issue(expand_pkg::OP_VIU, expand_pkg::VIU_RI, 1'b0);
      end
      2:
      begin
        name = "viu_0r";
        i    = make_issue(expand_pkg::OP_VIU, expand_pkg::VIU_0R, 1'b0);
      end
      3:
      begin
        name = "vau0";
        i    = make_issue(expand_pkg::OP_VAU0, expand_pkg::VIU_RR, 1'b0);
      end
      4:
      begin
        name = "vau1_fma";
        i    = make_issue(expand_pkg::OP_VAU1, expand_pkg::VIU_RR, 1'b1);
      end
      5:
      begin
        name = "vau1_2op";
        i    = make_issue(expand_pkg::OP_VAU1, expand_pkg::VIU_RR, 1'b0);
      end
      default:
      begin
        name = "vldq";
        i    = make_issue(expand_pkg::OP_VLDQ, expand_pkg::VIU_RR, 1'b0);
      end
    endcase
    test_name = {phase, "_", name};
    send_issue(i);
    idle_cycles(ROUND - 1);
  endtask

  // Single-read operations can issue every cycle without slot overlap
  task automatic run_burst(input string name, input expand_pkg::op_t op,
                           input expand_pkg::viu_mode_t mode);
    test_name = name;
    repeat (N_BURST)
      send_issue(make_issue(op, mode, 1'b0));
    idle_cycles(ROUND - 1);
  endtask

  task automatic close_run;
    int fails;
    fails = UUT.u_sva.fail_count;
    $display("Closing: %0d assertion failures, %0d timeouts", fails, timeouts);
    if (fails == 0 && timeouts == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  endtask

  initial
  begin
    issue     = '0;
    timeouts  = 0;
    test_name = "reset_idle";
    void'($urandom(SEED));
    wait (reset == 1'b0);
    idle_cycles(10);

    for (int v = 0; v < N_SINGLE; v++)
      run_variant("single", v);

    run_burst("burst_viu_ri", expand_pkg::OP_VIU, expand_pkg::VIU_RI);
    run_burst("burst_viu_0r", expand_pkg::OP_VIU, expand_pkg::VIU_0R);
    run_burst("burst_vldq", expand_pkg::OP_VLDQ, expand_pkg::VIU_RR);

    repeat (N_RANDOM)
      run_variant("random", int'($urandom_range(N_SINGLE - 1)));

    close_run();
  end

  // Watchdog
  initial
  begin
    #((TEST_CYCLES + `EXP_WR_DEPTH + MARGIN) * 10);
    timeouts++;
    $display("Timeout: the stimulus did not finish in the expected number of cycles");
    close_run();
  end

endmodule

// File: dv/vxu_expand_sva.sv
`timescale 1ns/1ns
`include "expand_macros.svh"

module vxu_expand_sva
(
  input logic                clk,
  input logic                reset,
  input expand_pkg::issue_t  issue,
  input expand_pkg::rd_cmd_t rd_cmd,
  input expand_pkg::wr_cmd_t wr_cmd,
  input expand_pkg::fu_cmd_t fu_cmd
);

  int fail_count = 0;

  // hist[j] holds the issue that is due at slot j this cycle
  expand_pkg::issue_t  hist [`EXP_WR_DEPTH];
  expand_pkg::rd_cmd_t exp_rd;
  expand_pkg::wr_cmd_t exp_wr;
  expand_pkg::fu_cmd_t exp_fu;

  function automatic expand_pkg::rd_cmd_t rd_make
  (
    input expand_pkg::issue_t    i,
    input logic [`EXP_REG_W-1:0] addr,
    input logic [1:0]            oplen,
    input logic [4:0]            rmask
  );
    return {1'b1, i.last, i.cnt, addr, oplen, rmask};
  endfunction

  // Port enables cleared by the operand zero flags
  function automatic logic [4:0] zero_mask(input expand_pkg::issue_t i);
    return {i.vr_zero, i.vt_zero, i.vs_zero, i.vt_zero, i.vs_zero};
  endfunction

  function automatic expand_pkg::rd_cmd_t read_at(input expand_pkg::issue_t i, input int slot);
    expand_pkg::rd_cmd_t c;
    c = '0;
    case (i.op)
      expand_pkg::OP_VIU:
      begin
        if (i.viu_mode == expand_pkg::VIU_RR)
        begin
          if (slot == 0)
            c = rd_make(i, i.vs, 2'd1, 5'b00000);
          else if (slot == 1)
            c = rd_make(i, i.vt, 2'd0, 5'b00000);
        end
        else if (slot == 0)
        begin
          c = rd_make(i, (i.viu_mode == expand_pkg::VIU_0R) ? i.vt : i.vs, 2'd0, 5'b00000);
        end
      end
      expand_pkg::OP_VAU0:
      begin
        if (slot == 0)
          c = rd_make(i, i.vs, 2'd1, 5'b00000);
        else if (slot == 1)
          c = rd_make(i, i.vt, 2'd0, 5'b00011 & ~zero_mask(i));
      end
      expand_pkg::OP_VAU1:
      begin
        if (slot == 0)
          c = rd_make(i, i.vs, 2'd2, 5'b00000);
        else if (i.vau1_fn[2] && slot == 1)
          c = rd_make(i, i.vt, 2'd1, 5'b00000);
        else if (i.vau1_fn[2] && slot == 2)
          c = rd_make(i, i.vr, 2'd0, 5'b11100 & ~zero_mask(i));
        else if (!i.vau1_fn[2] && slot == 1)
          c = rd_make(i, i.vt, 2'd0, 5'b10100 & ~{i.vt_zero, 1'b0, i.vs_zero, 2'b00});
      end
      default:
      begin
        c = '0;
      end
    endcase
    return c;
  endfunction

  function automatic expand_pkg::wr_cmd_t write_at(input expand_pkg::issue_t i, input int slot);
    expand_pkg::wr_cmd_t c;
    int                  w;
    c = '0;
    w = -1;
    case (i.op)
      expand_pkg::OP_VIU:
      begin
        w = (i.viu_mode == expand_pkg::VIU_RR) ? `EXP_INT_STAGES + 2 : `EXP_INT_STAGES + 1;
        c.sel = expand_pkg::WSEL_VIU;
      end
      expand_pkg::OP_VAU0:
      begin
        w = `EXP_IMUL_STAGES + 2;
        c.sel = expand_pkg::WSEL_VAU0;
      end
      expand_pkg::OP_VAU1:
      begin
        w = i.vau1_fn[2] ? `EXP_FMA_STAGES + 3 : `EXP_FMA_STAGES + 2;
        c.sel = expand_pkg::WSEL_VAU1;
      end
      expand_pkg::OP_VLDQ:
      begin
        w = 0;
        c.sel = expand_pkg::WSEL_LDQ;
      end
      default:
      begin
        w = -1;
      end
    endcase
    if (w != slot)
      return '0;
    c.en   = 1'b1;
    c.last = i.last;
    c.cnt  = i.cnt;
    c.addr = i.vd;
    return c;
  endfunction

  function automatic expand_pkg::fu_cmd_t fire_at(input expand_pkg::issue_t i, input int slot);
    expand_pkg::fu_cmd_t c;
    int                  f;
    c           = '0;
    f           = -1;
    c.en        = 1'b1;
    c.unit      = i.op;
    c.viu_mode  = i.viu_mode;
    c.imm       = i.imm;
    c.src0_zero = i.vs_zero;
    case (i.op)
      expand_pkg::OP_VIU:
      begin
        f    = (i.viu_mode == expand_pkg::VIU_RR) ? 1 : 0;
        c.fn = i.viu_fn;
        c.src1_zero = (i.viu_mode == expand_pkg::VIU_RR) ? i.vt_zero : 1'b0;
      end
      expand_pkg::OP_VAU0:
      begin
        f    = 1;
        c.fn = {2'b00, i.vau0_fn};
      end
      expand_pkg::OP_VAU1:
      begin
        f    = i.vau1_fn[2] ? 2 : 1;
        c.fn = {1'b0, i.vau1_fn};
      end
      expand_pkg::OP_VLDQ:
      begin
        f = 0;
      end
      default:
      begin
        f = -1;
      end
    endcase
    if (f != slot)
      c = '0;
    return c;
  endfunction

  // Operand fields only mean something for the integer unit
  function automatic logic fire_match(input expand_pkg::fu_cmd_t a, input expand_pkg::fu_cmd_t e);
    if (a.en != e.en)
      return 1'b0;
    if (!e.en)
      return 1'b1;
    if (a.unit != e.unit || a.fn != e.fn)
      return 1'b0;
    if (e.unit != expand_pkg::OP_VIU)
      return 1'b1;
    return a.viu_mode == e.viu_mode && a.src0_zero == e.src0_zero &&
           a.src1_zero == e.src1_zero && a.imm == e.imm;
  endfunction

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int j = 0; j < `EXP_WR_DEPTH; j++)
        hist[j] <= '0;
    end
    else
    begin
      hist[0] <= issue;
      for (int j = 1; j < `EXP_WR_DEPTH; j++)
        hist[j] <= hist[j-1];
    end
  end

  // Issues never share a slot, so the expected commands can be ORed
  always_comb
  begin
    exp_rd = '0;
    exp_fu = '0;
    exp_wr = '0;
    for (int j = 0; j < `EXP_RD_DEPTH; j++)
    begin
      exp_rd = exp_rd | read_at(hist[j], j);
      exp_fu = exp_fu | fire_at(hist[j], j);
    end
    for (int j = 0; j < `EXP_WR_DEPTH; j++)
      exp_wr = exp_wr | write_at(hist[j], j);
  end

  a_reset_idle: assert property (@(posedge clk)
    $fell(reset) |-> !rd_cmd.en && !wr_cmd.en && !fu_cmd.en)
  else
  begin
    fail_count++;
    $error("%s: a command is enabled right after reset", tb_vxu_expand.test_name);
  end

  a_read: assert property (@(posedge clk) disable iff (reset)
    rd_cmd.en == exp_rd.en && (!exp_rd.en || rd_cmd == exp_rd))
  else
  begin
    fail_count++;
    $error("** Error %s: rd_cmd expected %h, actual %h",
           tb_vxu_expand.test_name, $sampled(exp_rd), $sampled(rd_cmd));
  end

  a_write: assert property (@(posedge clk) disable iff (reset)
    wr_cmd.en == exp_wr.en && (!exp_wr.en || wr_cmd == exp_wr))
  else
  begin
    fail_count++;
    $error("** Error %s: wr_cmd expected %h, actual %h",
           tb_vxu_expand.test_name, $sampled(exp_wr), $sampled(wr_cmd));
  end

  a_fire: assert property (@(posedge clk) disable iff (reset)
    fire_match(fu_cmd, exp_fu))
  else
  begin
    fail_count++;
    $error("** Error %s: fu_cmd expected %h, actual %h",
           tb_vxu_expand.test_name, $sampled(exp_fu), $sampled(fu_cmd));
  end

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen
(
  output logic clk,
  output logic reset
);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held for two rising edges, released on a falling edge
  initial
  begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

// File: verilog/vxu_expand.sv
`timescale 1ns/1ns
`include "expand_macros.svh"

module vxu_expand
(
  input  logic                clk,
  input  logic                reset,
  input  expand_pkg::issue_t  issue,
  output expand_pkg::rd_cmd_t rd_cmd,
  output expand_pkg::wr_cmd_t wr_cmd,
  output expand_pkg::fu_cmd_t fu_cmd
);

  logic [`EXP_RD_DEPTH-1:0] rd_ins;
  expand_pkg::rd_cmd_t      rd_data [`EXP_RD_DEPTH];
  logic [`EXP_WR_DEPTH-1:0] wr_ins;
  expand_pkg::wr_cmd_t      wr_data [`EXP_WR_DEPTH];
  logic [`EXP_RD_DEPTH-1:0] fu_ins;
  expand_pkg::fu_cmd_t      fu_data [`EXP_RD_DEPTH];

  expand_ctrl u_ctrl
  (
    .issue   (issue),
    .rd_ins  (rd_ins),
    .rd_data (rd_data),
    .wr_ins  (wr_ins),
    .wr_data (wr_data),
    .fu_ins  (fu_ins),
    .fu_data (fu_data)
  );

  // Register file read schedule
  expand_shift_buf
  #(
    .DEPTH     (`EXP_RD_DEPTH),
    .payload_t (expand_pkg::rd_cmd_t)
  ) u_rd_buf
  (
    .clk      (clk),
    .reset    (reset),
    .ins      (rd_ins),
    .ins_data (rd_data),
    .out      (rd_cmd)
  );

  // Write schedule spans the unit pipeline latency
  expand_shift_buf
  #(
    .DEPTH     (`EXP_WR_DEPTH),
    .payload_t (expand_pkg::wr_cmd_t)
  ) u_wr_buf
  (
    .clk      (clk),
    .reset    (reset),
    .ins      (wr_ins),
    .ins_data (wr_data),
    .out      (wr_cmd)
  );

  // Fires for every unit, tagged by unit
  expand_shift_buf
  #(
    .DEPTH     (`EXP_RD_DEPTH),
    .payload_t (expand_pkg::fu_cmd_t)
  ) u_fu_buf
  (
    .clk      (clk),
    .reset    (reset),
    .ins      (fu_ins),
    .ins_data (fu_data),
    .out      (fu_cmd)
  );

endmodule

// File: verilog/expand_shift_buf.sv
`timescale 1ns/1ns

module expand_shift_buf
#(
  parameter int  DEPTH     = 3,
  parameter type payload_t = logic [7:0]
)
(
  input  logic             clk,
  input  logic             reset,
  input  logic [DEPTH-1:0] ins,
  input  payload_t         ins_data [DEPTH],
  output payload_t         out
);

  // En leads every payload struct, so it is the MSB
  localparam int EN_BIT = $bits(payload_t) - 1;

  payload_t slot      [DEPTH];
  payload_t slot_next [DEPTH];

  always_comb
  begin
    for (int i = 0; i < DEPTH - 1; i++)
    begin
      if (ins[i])
      begin
        slot_next[i] = ins_data[i];
      end
      else
      begin
        slot_next[i] = slot[i+1];
      end
    end

    // Top slot refills empty
    if (ins[DEPTH-1])
    begin
      slot_next[DEPTH-1] = ins_data[DEPTH-1];
    end
    else
    begin
      slot_next[DEPTH-1] = '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        slot[i][EN_BIT] <= 1'b0;
      end
    end
    else
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        slot[i] <= slot_next[i];
      end
    end
  end

  assign out = slot[0];

endmodule

// File: verilog/expand_ctrl.sv
`timescale 1ns/1ns
`include "expand_macros.svh"

module expand_ctrl
(
  input  expand_pkg::issue_t       issue,
  output logic [`EXP_RD_DEPTH-1:0] rd_ins,
  output expand_pkg::rd_cmd_t      rd_data [`EXP_RD_DEPTH],
  output logic [`EXP_WR_DEPTH-1:0] wr_ins,
  output expand_pkg::wr_cmd_t      wr_data [`EXP_WR_DEPTH],
  output logic [`EXP_RD_DEPTH-1:0] fu_ins,
  output expand_pkg::fu_cmd_t      fu_data [`EXP_RD_DEPTH]
);

  localparam int RD_PTR_W = $clog2(`EXP_RD_DEPTH);
  localparam int WR_PTR_W = $clog2(`EXP_WR_DEPTH);

  logic                fma;
  logic                fu_valid;
  logic [RD_PTR_W-1:0] fu_slot;
  expand_pkg::fu_cmd_t fu_cmd;
  logic                wr_valid;
  logic [WR_PTR_W-1:0] wr_slot;
  expand_pkg::wsel_t   wr_sel;
  expand_pkg::wr_cmd_t wr_cmd;

  function automatic expand_pkg::rd_cmd_t rd_entry
  (
    input logic                  last,
    input logic [`EXP_CNT_W-1:0] cnt,
    input logic [`EXP_REG_W-1:0] addr,
    input logic [1:0]            oplen,
    input logic [4:0]            rmask
  );
    expand_pkg::rd_cmd_t cmd;
    cmd.en    = 1'b1;
    cmd.last  = last;
    cmd.cnt   = cnt;
    cmd.addr  = addr;
    cmd.oplen = oplen;
    cmd.rmask = rmask;
    return cmd;
  endfunction

  assign fma = issue.vau1_fn[2];

  // Read schedule, one operand per slot
  always_comb
  begin
    rd_ins = '0;
    for (int i = 0; i < `EXP_RD_DEPTH; i++)
    begin
      rd_data[i] = '0;
    end

    case (issue.op)
      expand_pkg::OP_VIU:
      begin
        case (issue.viu_mode)
          expand_pkg::VIU_RR:
          begin
            rd_ins[1:0] = 2'b11;
            rd_data[0]  = rd_entry(issue.last, issue.cnt, issue.vs, 2'd1, 5'b00000);
            rd_data[1]  = rd_entry(issue.last, issue.cnt, issue.vt, 2'd0, 5'b00000);
          end
          expand_pkg::VIU_0R:
          begin
            rd_ins[0]  = 1'b1;
            rd_data[0] = rd_entry(issue.last, issue.cnt, issue.vt, 2'd0, 5'b00000);
          end
          // Unused mode encoding decodes as register-immediate
          default:
          begin
            rd_ins[0]  = 1'b1;
            rd_data[0] = rd_entry(issue.last, issue.cnt, issue.vs, 2'd0, 5'b00000);
          end
        endcase
      end
      expand_pkg::OP_VAU0:
      begin
        rd_ins[1:0] = 2'b11;
        rd_data[0]  = rd_entry(issue.last, issue.cnt, issue.vs, 2'd1, 5'b00000);
        rd_data[1]  = rd_entry(issue.last, issue.cnt, issue.vt, 2'd0,
                               {3'b000, ~issue.vt_zero, ~issue.vs_zero});
      end
      expand_pkg::OP_VAU1:
      begin
        rd_ins[0]  = 1'b1;
        rd_data[0] = rd_entry(issue.last, issue.cnt, issue.vs, 2'd2, 5'b00000);
        if (fma)
        begin
          rd_ins[2:1] = 2'b11;
          rd_data[1]  = rd_entry(issue.last, issue.cnt, issue.vt, 2'd1, 5'b00000);
          rd_data[2]  = rd_entry(issue.last, issue.cnt, issue.vr, 2'd0,
                                 {~issue.vr_zero, ~issue.vt_zero, ~issue.vs_zero, 2'b00});
        end
        else
        begin
          // Two-operand form sends vt to the third FMA port
          rd_ins[1]  = 1'b1;
          rd_data[1] = rd_entry(issue.last, issue.cnt, issue.vt, 2'd0,
                                {~issue.vt_zero, 1'b0, ~issue.vs_zero, 2'b00});
        end
      end
      default:
      begin
        rd_ins = '0;
      end
    endcase
  end

  // Fire slot and write slot per unit
  always_comb
  begin
    fu_valid      = 1'b0;
    fu_slot       = '0;
    fu_cmd        = '0;
    fu_cmd.en     = 1'b1;
    fu_cmd.unit   = issue.op;
    wr_valid      = 1'b0;
    wr_slot       = '0;
    wr_sel        = expand_pkg::WSEL_VIU;

    case (issue.op)
      expand_pkg::OP_VIU:
      begin
        fu_valid         = 1'b1;
        fu_cmd.fn        = issue.viu_fn;
        fu_cmd.viu_mode  = issue.viu_mode;
        fu_cmd.imm       = issue.imm;
        fu_cmd.src0_zero = issue.vs_zero;
        wr_valid         = 1'b1;
        wr_sel           = expand_pkg::WSEL_VIU;
        if (issue.viu_mode == expand_pkg::VIU_RR)
        begin
          fu_slot          = RD_PTR_W'(1);
          fu_cmd.src1_zero = issue.vt_zero;
          wr_slot          = WR_PTR_W'(`EXP_INT_STAGES + 2);
        end
        else
        begin
          wr_slot = WR_PTR_W'(`EXP_INT_STAGES + 1);
        end
      end
      expand_pkg::OP_VAU0:
      begin
        fu_valid  = 1'b1;
        fu_slot   = RD_PTR_W'(1);
        fu_cmd.fn = {2'b00, issue.vau0_fn};
        wr_valid  = 1'b1;
        wr_slot   = WR_PTR_W'(`EXP_IMUL_STAGES + 2);
        wr_sel    = expand_pkg::WSEL_VAU0;
      end
      expand_pkg::OP_VAU1:
      begin
        fu_valid  = 1'b1;
        fu_slot   = fma ? RD_PTR_W'(2) : RD_PTR_W'(1);
        fu_cmd.fn = {1'b0, issue.vau1_fn};
        wr_valid  = 1'b1;
        wr_slot   = fma ? WR_PTR_W'(`EXP_FMA_STAGES + 3) : WR_PTR_W'(`EXP_FMA_STAGES + 2);
        wr_sel    = expand_pkg::WSEL_VAU1;
      end
      expand_pkg::OP_VLDQ:
      begin
        fu_valid = 1'b1;
        wr_valid = 1'b1;
        wr_sel   = expand_pkg::WSEL_LDQ;
      end
      default:
      begin
        fu_valid = 1'b0;
      end
    endcase
  end

  always_comb
  begin
    wr_cmd      = '0;
    wr_cmd.en   = 1'b1;
    wr_cmd.last = issue.last;
    wr_cmd.cnt  = issue.cnt;
    wr_cmd.addr = issue.vd;
    wr_cmd.sel  = wr_sel;
  end

  // Buffers only load the slot whose insert bit is set
  always_comb
  begin
    for (int i = 0; i < `EXP_RD_DEPTH; i++)
    begin
      fu_ins[i]  = fu_valid && (fu_slot == RD_PTR_W'(i));
      fu_data[i] = fu_cmd;
    end
    for (int i = 0; i < `EXP_WR_DEPTH; i++)
    begin
      wr_ins[i]  = wr_valid && (wr_slot == WR_PTR_W'(i));
      wr_data[i] = wr_cmd;
    end
  end

endmodule

// File: verilog/expand_pkg.sv
`include "expand_macros.svh"

package expand_pkg;

  // Operation issued by the sequencer
  typedef enum logic [2:0]
  {
    OP_NONE = 3'd0,
    OP_VIU  = 3'd1,
    OP_VAU0 = 3'd2,
    OP_VAU1 = 3'd3,
    OP_VLDQ = 3'd4
  } op_t;

  // Integer unit operand modes
  typedef enum logic [1:0]
  {
    VIU_RR = 2'd0,
    VIU_RI = 2'd1,
    VIU_0R = 2'd2
  } viu_mode_t;

  // Register file write source
  typedef enum logic [1:0]
  {
    WSEL_VAU0 = 2'd0,
    WSEL_VAU1 = 2'd1,
    WSEL_VIU  = 2'd2,
    WSEL_LDQ  = 2'd3
  } wsel_t;

  // One issued vector operation
  typedef struct packed
  {
    op_t                    op;
    logic                   last;
    logic [`EXP_CNT_W-1:0]  cnt;
    logic [`EXP_REG_W-1:0]  vs;
    logic [`EXP_REG_W-1:0]  vt;
    logic [`EXP_REG_W-1:0]  vr;
    logic [`EXP_REG_W-1:0]  vd;
    logic                   vs_zero;
    logic                   vt_zero;
    logic                   vr_zero;
    viu_mode_t              viu_mode;
    logic [3:0]             viu_fn;
    logic [1:0]             vau0_fn;
    // Bit 2 selects the 3-operand FMA
    logic [2:0]             vau1_fn;
    logic [`EXP_DATA_W-1:0] imm;
  } issue_t;

  // Register file read command
  typedef struct packed
  {
    logic                  en;
    logic                  last;
    logic [`EXP_CNT_W-1:0] cnt;
    logic [`EXP_REG_W-1:0] addr;
    // Counts down to 0 on the final operand
    logic [1:0]            oplen;
    // Bits 0-1 feed VAU0, bits 2-4 feed VAU1
    logic [4:0]            rmask;
  } rd_cmd_t;

  // Register file write command
  typedef struct packed
  {
    logic                  en;
    logic                  last;
    logic [`EXP_CNT_W-1:0] cnt;
    logic [`EXP_REG_W-1:0] addr;
    wsel_t                 sel;
  } wr_cmd_t;

  // Functional unit fire command, shared by all units
  typedef struct packed
  {
    logic                   en;
    op_t                    unit;
    logic [3:0]             fn;
    viu_mode_t              viu_mode;
    logic                   src0_zero;
    logic                   src1_zero;
    logic [`EXP_DATA_W-1:0] imm;
  } fu_cmd_t;

endpackage

// File: verilog/expand_macros.svh
`ifndef EXPAND_MACROS_SVH
`define EXPAND_MACROS_SVH

// Shift buffer depths

// Reads and fires reach at most two slots past issue
`define EXP_RD_DEPTH 3

// Writes must cover the longest FMA pipeline plus its three reads
`define EXP_WR_DEPTH 8

// Functional unit pipeline stages

// Integer unit
`define EXP_INT_STAGES 2

// Integer multiplier
`define EXP_IMUL_STAGES 3

// Fused multiply-add
`define EXP_FMA_STAGES 4

// Datapath widths

// Register address within one bank
`define EXP_REG_W 8

// Element count within one bank
`define EXP_CNT_W 3

// Scalar immediate operand
`define EXP_DATA_W 32

`endif
